/* hw/bus_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_decoder
  import pin_ctrl_pkg::*;
#(
  parameter int N_PINS = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  bus_req_t               bus_req,
  output bus_req_t               chan_req,
  output logic [N_PINS-1:0]      chan_sel,
  output logic                   global_wr,
  output logic [DATA_W-1:0]      global_data,
  input  logic [N_PINS-1:0][15:0] chan_rd_data,
  output logic [15:0]            rd_data,
  output logic                   rd_valid
);

  bus_req_t req_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else begin
      req_q <= bus_req;
    end
  end

  assign chan_req = req_q;  // every channel sees the same registered request

  always_comb begin
    for (int i = 0; i < N_PINS; i++) begin
      chan_sel[i] = (req_q.addr[15:8] == 8'(i));
    end
  end

  assign global_wr   = req_q.wr && req_q.addr[15:8] == GLOBAL_SEL &&
                       req_q.addr[7:0] == REG_GLOBAL_CMD;
  assign global_data = req_q.wdata;

  // channel read data is registered once more inside the channel
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= req_q.rd;
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < N_PINS; i++) begin
      rd_data = rd_data | chan_rd_data[i];  // unselected channels return zero
    end
  end

endmodule

`default_nettype wire

/* hw/phase_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module phase_accumulator
  import pin_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] phase_inc,
  input  logic              clear,
  input  logic              force_high,
  output logic              phase_msb
);

  logic [DATA_W-1:0] phase;

  // output frequency is about f_clk * phase_inc / 2^32
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (clear) begin
      phase <= '0;
    end else if (force_high) begin
      phase <= '1;  // all ones keeps the msb high for a constant level
    end else begin
      phase <= phase + phase_inc;
    end
  end

  assign phase_msb = phase[DATA_W-1];

endmodule

`default_nettype wire

/* hw/pin_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module pin_channel
  import pin_ctrl_pkg::*;
#(
  parameter int unsigned POSITION = 0
) (
  input  logic              clk,
  input  logic              reset,
  input  bus_req_t          req,
  input  logic              sel,
  input  logic [DATA_W-1:0] current_time,
  input  logic [7:0]        scan_sel,
  output logic [15:0]       rd_data,
  output sample_rec_t       sample_rec,
  output logic              rec_valid,
  output logic              pin_out,
  output logic              pin_oe,
  input  logic              pin_in
);

  chan_state_t       state;
  chan_state_t       next_state;
  logic [DATA_W-1:0] command;
  logic [DATA_W-1:0] phase_inc;
  logic [DATA_W-1:0] end_time;
  logic [DATA_W-1:0] rec_start;
  logic [DATA_W-1:0] sample_rate;
  logic [DATA_W-1:0] rate_cnt;     // counts down to the next sample
  logic              sample_value;
  logic [15:0]       sample_count;
  logic              wr_en;
  logic              time_run;
  logic              in_window;
  logic              clear_cmd;
  logic              clear_rec;
  logic              clear_smp;
  logic              load_rate;
  logic              take_smp;
  logic              dec_rate;
  logic              clear_acc;
  logic              force_high;

  assign wr_en     = sel && req.wr;
  assign time_run  = (current_time != '0);
  assign in_window = (rec_start != '0) && (rec_start < current_time) &&
                     (current_time <= end_time);

  // the host keeps one idle cycle between writes, so a clear from the FSM
  // and a new command never meet in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      command <= '0;
    end else if (clear_cmd) begin
      command <= '0;
    end else if (wr_en && req.addr[7:0] == REG_LOCAL_CMD) begin
      command <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_inc   <= '0;
      end_time    <= '0;
      sample_rate <= '0;
      rec_start   <= '0;
    end else begin
      if (wr_en && req.addr[7:0] == REG_PHASE_INC) phase_inc <= req.wdata;
      if (wr_en && req.addr[7:0] == REG_END_TIME) end_time <= req.wdata;
      if (wr_en && req.addr[7:0] == REG_SAMPLE_RATE) sample_rate <= req.wdata;
      if (clear_rec) begin
        rec_start <= '0;  // a finished window does not restart
      end else if (wr_en && req.addr[7:0] == REG_REC_START) begin
        rec_start <= req.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    clear_cmd  = 1'b0;
    clear_rec  = 1'b0;
    clear_smp  = 1'b0;
    load_rate  = 1'b0;
    take_smp   = 1'b0;
    dec_rate   = 1'b0;
    case (state)
      IDLE: begin
        load_rate = 1'b1;
        if (!time_run) begin
          next_state = IDLE;  // nothing happens before the timebase runs
        end else if (in_window) begin
          next_state = STREAM_IN;
        end else if (command != '0) begin
          clear_cmd = 1'b1;
          if (command == CMD_CONST) next_state = CONST_OUT;
          else if (command == CMD_SQUARE) next_state = SQUARE_OUT;
          else if (command == CMD_STREAM) next_state = STREAM_IN;
        end
      end
      CONST_OUT: begin
        if (command == CMD_RESET || current_time >= end_time) begin
          clear_cmd  = 1'b1;
          next_state = IDLE;
        end
      end
      SQUARE_OUT: begin
        // a zero end time means run until reset
        if (command == CMD_RESET || (end_time != '0 && current_time >= end_time)) begin
          clear_cmd  = 1'b1;
          next_state = IDLE;
        end
      end
      STREAM_IN: begin
        if (rate_cnt == 1) take_smp = 1'b1;
        else dec_rate = 1'b1;
        if (command == CMD_RESET) begin
          clear_cmd  = 1'b1;
          clear_rec  = 1'b1;
          clear_smp  = 1'b1;
          next_state = IDLE;
        end else if (end_time != '0 && current_time >= end_time) begin
          clear_rec  = 1'b1;  // count stays readable after the window
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || clear_smp) begin
      rate_cnt     <= '0;
      sample_value <= 1'b0;
      sample_count <= '0;
    end else begin
      if (load_rate || take_smp) rate_cnt <= sample_rate;
      else if (dec_rate) rate_cnt <= rate_cnt - 1'b1;
      if (take_smp) begin
        sample_value <= pin_in;
        sample_count <= sample_count + 1'b1;
      end
    end
  end

  // preload all ones before the first CONST_OUT cycle so the pin starts high
  assign force_high = (next_state == CONST_OUT);
  assign clear_acc  = (state == CONST_OUT || state == SQUARE_OUT) && next_state == IDLE;

  phase_accumulator u_phase (
    .clk       (clk),
    .reset     (reset),
    .phase_inc (phase_inc),
    .clear     (clear_acc),
    .force_high(force_high),
    .phase_msb (pin_out)
  );

  assign pin_oe = (state == CONST_OUT) || (state == SQUARE_OUT);

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (sel && req.rd) begin
      case (req.addr[7:0])
        REG_SAMPLE_VALUE: rd_data <= {15'b0, sample_value};
        REG_SAMPLE_COUNT: rd_data <= sample_count;
        REG_STATUS:       rd_data <= 16'(POSITION);
        default:          rd_data <= '0;
      endcase
    end else begin
      rd_data <= '0;  // zero lets the decoder OR all channels
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= (scan_sel == 8'(POSITION));
    end
  end

  always_ff @(posedge clk) begin
    sample_rec <= '{count: sample_count, channel: 15'(POSITION), value: sample_value};
  end

endmodule

`default_nettype wire

/* hw/pin_ctrl_pkg.sv */
`default_nettype none

package pin_ctrl_pkg;

  localparam int DATA_W = 32;  // bus data width, also used for time and rate values
  localparam int ADDR_W = 16;  // upper byte picks the channel, lower byte the register

  localparam logic [7:0] GLOBAL_SEL = 8'd255;  // upper address byte of the global block

  // register offsets in the lower address byte
  localparam logic [7:0] REG_GLOBAL_CMD   = 8'd0;
  localparam logic [7:0] REG_PHASE_INC    = 8'd1;
  localparam logic [7:0] REG_END_TIME     = 8'd2;
  localparam logic [7:0] REG_LOCAL_CMD    = 8'd3;
  localparam logic [7:0] REG_SAMPLE_RATE  = 8'd4;
  localparam logic [7:0] REG_SAMPLE_VALUE = 8'd5;
  localparam logic [7:0] REG_REC_START    = 8'd6;
  localparam logic [7:0] REG_SAMPLE_COUNT = 8'd7;
  localparam logic [7:0] REG_STATUS       = 8'd8;

  // commands written to REG_LOCAL_CMD of a channel
  localparam logic [DATA_W-1:0] CMD_CONST  = 32'd2;
  localparam logic [DATA_W-1:0] CMD_SQUARE = 32'd3;
  localparam logic [DATA_W-1:0] CMD_STREAM = 32'd4;
  localparam logic [DATA_W-1:0] CMD_RESET  = 32'd5;

  // commands written to REG_GLOBAL_CMD of the global block
  localparam logic [DATA_W-1:0] GCMD_START = 32'd1;
  localparam logic [DATA_W-1:0] GCMD_STOP  = 32'd2;
  localparam logic [DATA_W-1:0] GCMD_CLEAR = 32'd3;

  typedef struct packed {
    logic              wr;     // one-cycle write strobe
    logic              rd;     // one-cycle read strobe
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] count;    // samples taken so far
    logic [14:0] channel;  // index of the channel that sent it
    logic        value;    // last sampled pin level
  } sample_rec_t;

  // one-hot channel state
  typedef enum logic [3:0] {
    IDLE       = 4'b0001,
    CONST_OUT  = 4'b0010,
    SQUARE_OUT = 4'b0100,
    STREAM_IN  = 4'b1000
  } chan_state_t;

endpackage

`default_nettype wire

/* hw/pin_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pin_ctrl_top
  import pin_ctrl_pkg::*;
#(
  parameter int N_PINS = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  bus_req_t          bus_req,
  output logic [15:0]       rd_data,
  output logic              rd_valid,
  output sample_rec_t       sample_out,
  output logic              sample_valid,
  output logic [N_PINS-1:0] pin_out,
  output logic [N_PINS-1:0] pin_oe,
  input  logic [N_PINS-1:0] pin_in
);

  bus_req_t                  chan_req;
  logic [N_PINS-1:0]         chan_sel;
  logic                      global_wr;
  logic [DATA_W-1:0]         global_data;
  logic [N_PINS-1:0][15:0]   chan_rd_data;
  logic [DATA_W-1:0]         current_time;
  logic [7:0]                scan_sel;
  sample_rec_t [N_PINS-1:0]  chan_recs;
  logic [N_PINS-1:0]         chan_valid;

  bus_decoder #(.N_PINS(N_PINS)) u_decoder (
    .clk         (clk),
    .reset       (reset),
    .bus_req     (bus_req),
    .chan_req    (chan_req),
    .chan_sel    (chan_sel),
    .global_wr   (global_wr),
    .global_data (global_data),
    .chan_rd_data(chan_rd_data),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid)
  );

  time_base u_time (
    .clk         (clk),
    .reset       (reset),
    .cmd_wr      (global_wr),
    .cmd         (global_data),
    .current_time(current_time)
  );

  sample_scanner #(.N_PINS(N_PINS)) u_scanner (
    .clk         (clk),
    .reset       (reset),
    .scan_sel    (scan_sel),
    .chan_recs   (chan_recs),
    .chan_valid  (chan_valid),
    .sample_out  (sample_out),
    .sample_valid(sample_valid)
  );

  for (genvar i = 0; i < N_PINS; i++) begin : g_chan
    pin_channel #(.POSITION(i)) u_chan (
      .clk         (clk),
      .reset       (reset),
      .req         (chan_req),
      .sel         (chan_sel[i]),
      .current_time(current_time),
      .scan_sel    (scan_sel),
      .rd_data     (chan_rd_data[i]),
      .sample_rec  (chan_recs[i]),
      .rec_valid   (chan_valid[i]),
      .pin_out     (pin_out[i]),
      .pin_oe      (pin_oe[i]),
      .pin_in      (pin_in[i])
    );
  end

endmodule

`default_nettype wire

/* hw/sample_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_scanner
  import pin_ctrl_pkg::*;
#(
  parameter int N_PINS = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  output logic [7:0]               scan_sel,
  input  sample_rec_t [N_PINS-1:0] chan_recs,
  input  logic [N_PINS-1:0]        chan_valid,
  output sample_rec_t              sample_out,
  output logic                     sample_valid
);

  sample_rec_t merged;

  // one channel per cycle, wrapping after the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      scan_sel <= '0;
    end else if (scan_sel == 8'(N_PINS - 1)) begin
      scan_sel <= '0;
    end else begin
      scan_sel <= scan_sel + 1'b1;
    end
  end

  // only the answering channel passes the mask
  always_comb begin
    merged = '0;
    for (int i = 0; i < N_PINS; i++) begin
      if (chan_valid[i]) merged = merged | chan_recs[i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= |chan_valid;
    end
  end

  always_ff @(posedge clk) begin
    sample_out <= merged;
  end

endmodule

`default_nettype wire

/* hw/time_base.sv */
`timescale 1ns/100ps
`default_nettype none

module time_base
  import pin_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_wr,
  input  logic [DATA_W-1:0] cmd,
  output logic [DATA_W-1:0] current_time
);

  logic              run;    // timebase is counting
  logic [DATA_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else if (cmd_wr) begin
      if (cmd == GCMD_START) begin
        run <= 1'b1;
      end else if (cmd == GCMD_STOP) begin
        run <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (cmd_wr && cmd == GCMD_CLEAR) begin
      count <= '0;  // clear wins over counting in the same cycle
    end else if (run) begin
      count <= count + 1'b1;
    end
  end

  // channels see zero while stopped, so they all hold still
  assign current_time = run ? count : '0;

endmodule

`default_nettype wire

/* pin_ctrl.f */
hw/pin_ctrl_pkg.sv
hw/time_base.sv
hw/phase_accumulator.sv
hw/pin_channel.sv
hw/bus_decoder.sv
hw/sample_scanner.sv
hw/pin_ctrl_top.sv
testbench/pin_ctrl_tb.sv

/* testbench/pin_ctrl_golden.txt */
# op name a b c d e, all operands hex, unused ones 0
# W addr data | R addr exp tol | I pin_in | C cycles | P chan oe out
# E chan cycles exp tol | S chan count value wait tol
R status_ch0 0008 0 0 0 0
R status_ch1 0108 1 0 0 0
R status_ch2 0208 2 0 0 0
R status_ch3 0308 3 0 0 0
R unknown_reg 0109 0 0 0 0
W const_end_time 0002 40 0 0 0
W const_cmd 0003 2 0 0 0
C const_stopped 8 0 0 0 0
P const_stopped 0 0 0 0 0
W time_start ff00 1 0 0 0
C const_hold a 0 0 0 0
P const_hold 0 1 1 0 0
C const_after_end 60 0 0 0 0
P const_after_end 0 0 0 0 0
W square_inc 0101 40000000 0 0 0
W square_cmd 0103 3 0 0 0
C square_settle 4 0 0 0 0
E square_edges 1 40 10 1 0
W square_inc_zero 0101 0 0 0 0
W square_reset 0103 5 0 0 0
C square_drop 4 0 0 0 0
P square_drop 1 0 0 0 0
I stream_pins c 0 0 0 0
W stream_rate 0204 4 0 0 0
W stream_cmd 0203 4 0 0 0
C stream_wait 80 0 0 0 0
R stream_count 0207 20 1 0 0
R stream_value 0205 1 0 0 0
W stream_reset 0203 5 0 0 0
C stream_drop 4 0 0 0 0
R stream_cleared 0207 0 0 0 0
W window_rate 0304 2 0 0 0
W window_time_clear ff00 3 0 0 0
W window_end_time 0302 80 0 0 0
W window_start 0306 40 0 0 0
C window_before 20 0 0 0 0
R window_before_count 0307 0 0 0 0
P window_before 3 0 0 0 0
C window_inside 40 0 0 0 0
P window_inside 3 0 0 0 0
C window_after 40 0 0 0 0
R window_count 0307 1f 2 0 0
R window_value 0305 1 0 0 0
P window_after 3 0 0 0 0
S stream_ch0 0 0 0 8 0
S stream_ch1 1 0 0 1 0
S stream_ch2 2 0 0 1 0
S stream_ch3 3 1f 1 1 2

/* testbench/pin_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pin_ctrl_tb
  import pin_ctrl_pkg::*;
();

  localparam int N_PINS = 4;

  logic              clk;
  logic              reset;
  bus_req_t          bus_req;
  logic [15:0]       rd_data;
  logic              rd_valid;
  sample_rec_t       sample_out;
  logic              sample_valid;
  logic [N_PINS-1:0] pin_out;
  logic [N_PINS-1:0] pin_oe;
  logic [N_PINS-1:0] pin_in;

  string       op_q[$];    // one entry per operation line of the golden file
  string       name_q[$];
  logic [31:0] arg_q[$];   // five operands per operation
  int          cycles = 0;
  int          limit  = 0; // stays zero until the golden file is loaded

  pin_ctrl_top #(.N_PINS(N_PINS)) UUT (
    .clk         (clk),
    .reset       (reset),
    .bus_req     (bus_req),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .sample_out  (sample_out),
    .sample_valid(sample_valid),
    .pin_out     (pin_out),
    .pin_oe      (pin_oe),
    .pin_in      (pin_in)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      abort_run($sformatf("timeout: run went past %0d cycles", limit));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rd(input string name, input logic [15:0] exp,
                          input logic [15:0] act, input int tol);
    int diff;
    diff = int'(act) - int'(exp);
    if ($isunknown(act) || diff > tol || diff < -tol) begin
      abort_run($sformatf("MISMATCH %s: expected %h (+/- %0d), actual %h",
                          name, exp, tol, act));
    end
  endtask

  // pair is {pin_oe, pin_out}
  task automatic check_pin(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s: expected oe/out %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act, input int tol);
    if (act > exp + tol || act < exp - tol) begin
      abort_run($sformatf("MISMATCH %s: expected %0d (+/- %0d), actual %0d",
                          name, exp, tol, act));
    end
  endtask

  task automatic check_rec(input string name, input sample_rec_t exp,
                           input sample_rec_t act, input int tol);
    int diff;
    diff = int'(act.count) - int'(exp.count);
    if ($isunknown(act) || act.channel !== exp.channel || act.value !== exp.value ||
        diff > tol || diff < -tol) begin
      abort_run($sformatf("MISMATCH %s: expected ch %0d count %0d value %b, actual %s",
                          name, exp.channel, exp.count, exp.value,
                          $sformatf("ch %0d count %0d value %b",
                                    act.channel, act.count, act.value)));
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_req       = '0;
    bus_req.wr    = 1'b1;
    bus_req.addr  = addr[ADDR_W-1:0];
    bus_req.wdata = data;
    @(posedge clk);
    #1;
    bus_req = '0;
    @(posedge clk);
    #1;  // idle cycle before the next transaction
  endtask

  task automatic bus_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp, input int tol);
    int n;
    n            = 0;
    bus_req      = '0;
    bus_req.rd   = 1'b1;
    bus_req.addr = addr[ADDR_W-1:0];
    @(posedge clk);
    #1;
    bus_req = '0;
    while (!rd_valid && n < 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rd_valid) begin
      abort_run($sformatf("read of address %h in %s never got rd_valid", addr, name));
    end else begin
      check_rd(name, exp[15:0], rd_data, tol);
    end
  endtask

  task automatic count_edges(input string name, input int chan, input int n,
                             input int exp, input int tol);
    int   rises;
    logic prev;
    rises = 0;
    prev  = pin_out[chan];
    repeat (n) begin
      @(posedge clk);
      #1;
      if (pin_oe[chan] && pin_out[chan] && !prev) rises++;  // driven rising edges only
      prev = pin_out[chan];
    end
    check_count(name, exp, rises, tol);
  endtask

  task automatic expect_record(input string name, input int chan, input int count,
                               input logic value, input int max_wait, input int tol);
    sample_rec_t exp_rec;
    int          n;
    logic        found;
    n     = 0;
    found = 1'b0;
    while (!found && n < max_wait) begin
      @(posedge clk);
      #1;
      n++;
      found = sample_valid && sample_out.channel == 15'(chan);
    end
    exp_rec.count   = 16'(count);
    exp_rec.channel = 15'(chan);
    exp_rec.value   = value;
    if (!found) begin
      abort_run($sformatf("no sample record from channel %0d in %s", chan, name));
    end else begin
      check_rec(name, exp_rec, sample_out, tol);
    end
  endtask

  task automatic run_op(input int i);
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    op   = op_q[i];
    name = name_q[i];
    a    = arg_q[5*i];
    b    = arg_q[5*i+1];
    c    = arg_q[5*i+2];
    d    = arg_q[5*i+3];
    e    = arg_q[5*i+4];
    if (op == "W") bus_write(a, b);
    else if (op == "R") bus_read(name, a, b, int'(c));
    else if (op == "I") pin_in = a[N_PINS-1:0];
    else if (op == "C") begin
      repeat (a) begin
        @(posedge clk);
        #1;
      end
    end
    else if (op == "P") check_pin(name, {b[0], c[0]}, {pin_oe[a], pin_out[a]});
    else if (op == "E") count_edges(name, int'(a), int'(b), int'(c), int'(d));
    else if (op == "S") expect_record(name, int'(a), int'(b), c[0], int'(d), int'(e));
    else abort_run($sformatf("unknown operation %s in test %s", op, name));
  endtask

  initial begin : run_golden
    int               fd;
    int               r;
    int               waits;
    string            op;
    string            name;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      d;
    logic [31:0]      e;
    reg [8*256-1:0]   line_buf;
    reset   = 1'b1;
    bus_req = '0;
    pin_in  = '0;
    waits   = 0;
    fd = $fopen("testbench/pin_ctrl_golden.txt", "r");
    if (fd == 0) begin
      abort_run("could not open testbench/pin_ctrl_golden.txt");
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.substr(0, 0) == "#") begin
          r = $fgets(line_buf, fd);  // rest of a comment line
        end else begin
          r = $fscanf(fd, "%s %h %h %h %h %h", name, a, b, c, d, e);
          if (r != 6) abort_run($sformatf("malformed golden line for operation %s", op));
          op_q.push_back(op);
          name_q.push_back(name);
          arg_q.push_back(a);
          arg_q.push_back(b);
          arg_q.push_back(c);
          arg_q.push_back(d);
          arg_q.push_back(e);
          if (op == "C") waits += int'(a);
          else if (op == "E") waits += int'(b);
          else if (op == "S") waits += int'(d);
        end
      end
      $fclose(fd);
    end
    limit = 2 * (waits + 4 * op_q.size());
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(i);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
